// ==== rtl/gauss_pkg.sv ====
package gauss_pkg;

    // Q11.21 fixed point in a 32-bit word.
    localparam int FP_WIDTH = 32;
    localparam int FP_QFRAC = 21;

    localparam int NUM_LANES = 4;

    // Latency of each stage in one inverse CDF lane.
    localparam int FOLD_LATENCY     = 1;
    localparam int LN_LATENCY       = 2;
    localparam int MUL_LATENCY      = 1;
    localparam int SQRT_LATENCY     = 16;
    localparam int RATIONAL_LATENCY = 26;
    localparam int ICDF_LATENCY     = FOLD_LATENCY + LN_LATENCY + MUL_LATENCY
                                      + SQRT_LATENCY + RATIONAL_LATENCY;

    // Sum and sum of squares are Q27.21.
    localparam int ACC_WIDTH = 48;

    typedef enum logic [3:0] {
        REG_CTRL   = 4'd0,
        REG_TARGET = 4'd1,
        REG_STATUS = 4'd2,
        REG_COUNT  = 4'd3,
        REG_SUM_LO = 4'd4,
        REG_SUM_HI = 4'd5,
        REG_SQ_LO  = 4'd6,
        REG_SQ_HI  = 4'd7,
        REG_MAXABS = 4'd8
    } wb_addr_e;

    typedef enum logic [1:0] {RUN_IDLE, RUN_ISSUE, RUN_DRAIN, RUN_DONE} run_state_e;

    typedef struct packed {
        logic                       valid;
        logic signed [FP_WIDTH-1:0] value;
    } lane_sample_t;

endpackage

// ==== rtl/fx_ln_lut.sv ====
module fx_ln_lut
    import gauss_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       valid_in,
    input  logic [FP_WIDTH-1:0]        x,
    output logic                       valid_out,
    output logic signed [FP_WIDTH-1:0] ln_out
);

    localparam int IDX_W  = 6;
    localparam int FRAC_W = FP_QFRAC - 1 - IDX_W;

    typedef logic signed [FP_WIDTH-1:0] ln_table_t [0:2**IDX_W];

    // ln(1 + k/64) in Q11.21. The extra entry is ln 2.
    function automatic ln_table_t build_table();
        ln_table_t tab;
        for (int k = 0; k <= 2**IDX_W; k++) begin
            tab[k] = FP_WIDTH'($rtoi($ln(1.0 + real'(k) / 2.0**IDX_W) * 2.0**FP_QFRAC + 0.5));
        end
        return tab;
    endfunction

    localparam ln_table_t LN_TABLE = build_table();
    localparam logic signed [FP_WIDTH-1:0] LN2 = LN_TABLE[2**IDX_W];

    logic [4:0]                 lead;
    logic [FP_QFRAC-1:0]        norm;
    logic signed [5:0]          s1_exp;
    logic [IDX_W-1:0]           s1_idx;
    logic [FRAC_W-1:0]          s1_frac;
    logic                       s1_valid;
    logic signed [FP_WIDTH-1:0] lo;
    logic signed [FP_WIDTH-1:0] slope;
    logic signed [FP_WIDTH-1:0] interp;

    // Leading one of the fraction; x never exceeds 0.5.
    always_comb begin
        lead = '0;
        for (int i = 0; i < FP_QFRAC; i++) begin
            if (x[i]) lead = 5'(i);
        end
        norm = x[FP_QFRAC-1:0] << (FP_QFRAC - 1 - int'(lead));
    end

    always_ff @(posedge clk) begin
        s1_exp  <= 6'(lead) - 6'(FP_QFRAC);
        s1_idx  <= norm[FP_QFRAC-2 -: IDX_W];
        s1_frac <= norm[FRAC_W-1:0];
        if (!rst_n) s1_valid <= 1'b0;
        else        s1_valid <= valid_in;
    end

    // Linear interpolation between neighbouring table entries.
    always_comb begin
        lo     = LN_TABLE[s1_idx];
        slope  = LN_TABLE[s1_idx + 1] - lo;
        interp = (slope * $signed({1'b0, s1_frac})) >>> FRAC_W;
    end

    always_ff @(posedge clk) begin
        ln_out <= s1_exp * LN2 + lo + interp;
        if (!rst_n) valid_out <= 1'b0;
        else        valid_out <= s1_valid;
    end

endmodule

// ==== rtl/fx_sqrt.sv ====
module fx_sqrt
    import gauss_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid_in,
    input  logic [FP_WIDTH-1:0] a,
    output logic                valid_out,
    output logic [FP_WIDTH-1:0] sqrt_out
);

    // 16 root bits give 3 integer and 13 fraction bits.
    localparam int ROOT_W    = SQRT_LATENCY;
    localparam int FRAC_OUT  = ROOT_W - 3;
    localparam int PRE_SHIFT = 2 * FRAC_OUT - FP_QFRAC;
    localparam int REM_W     = ROOT_W + 4;

    logic [FP_WIDTH-1:0] rad  [SQRT_LATENCY+1];
    logic [REM_W-1:0]    rem  [SQRT_LATENCY+1];
    logic [ROOT_W-1:0]   root [SQRT_LATENCY+1];
    logic                vld  [SQRT_LATENCY+1];

    assign rad[0]  = a << PRE_SHIFT;
    assign rem[0]  = '0;
    assign root[0] = '0;
    assign vld[0]  = valid_in;

    for (genvar s = 0; s < SQRT_LATENCY; s++) begin : g_stage
        logic [REM_W-1:0] cat;
        logic [REM_W-1:0] trial;
        logic             fits;

        // Bring down two radicand bits and try root*4+1.
        assign cat   = {rem[s][REM_W-3:0], rad[s][FP_WIDTH-1 -: 2]};
        assign trial = REM_W'({root[s], 2'b01});
        assign fits  = cat >= trial;

        always_ff @(posedge clk) begin
            rad[s+1]  <= rad[s] << 2;
            rem[s+1]  <= fits ? cat - trial : cat;
            root[s+1] <= {root[s][ROOT_W-2:0], fits};
            if (!rst_n) vld[s+1] <= 1'b0;
            else        vld[s+1] <= vld[s];
        end
    end

    assign sqrt_out  = FP_WIDTH'(root[SQRT_LATENCY]) << (FP_QFRAC - FRAC_OUT);
    assign valid_out = vld[SQRT_LATENCY];

endmodule

// ==== rtl/zs_rational.sv ====
module zs_rational
    import gauss_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       valid_in,
    input  logic                       negate,
    input  logic [FP_WIDTH-1:0]        t,
    output logic                       valid_out,
    output logic signed [FP_WIDTH-1:0] z
);

    // Three Horner stages and one output stage around the divider.
    localparam int  DIV_STAGES = RATIONAL_LATENCY - 4;
    localparam int  REM_W      = FP_WIDTH + 2;
    localparam real SCALE      = 2.0 ** FP_QFRAC;

    typedef logic signed [FP_WIDTH-1:0] fx_t;

    localparam fx_t C0  = FP_WIDTH'($rtoi(2.515517 * SCALE + 0.5));
    localparam fx_t C1  = FP_WIDTH'($rtoi(0.802853 * SCALE + 0.5));
    localparam fx_t C2  = FP_WIDTH'($rtoi(0.010328 * SCALE + 0.5));
    localparam fx_t D1  = FP_WIDTH'($rtoi(1.432788 * SCALE + 0.5));
    localparam fx_t D2  = FP_WIDTH'($rtoi(0.189269 * SCALE + 0.5));
    localparam fx_t D3  = FP_WIDTH'($rtoi(0.001308 * SCALE + 0.5));
    localparam fx_t ONE = fx_t'(1) <<< FP_QFRAC;

    function automatic fx_t fx_mul(fx_t a, fx_t b);
        logic signed [2*FP_WIDTH-1:0] p;
        p = a * b;
        return p[FP_QFRAC +: FP_WIDTH];
    endfunction

    fx_t        h1_num, h1_den, h1_t;
    fx_t        h2_num, h2_den, h2_t;
    fx_t        h3_num, h3_den, h3_t;
    logic [2:0] h_neg;
    logic [2:0] h_vld;

    always_ff @(posedge clk) begin
        h1_num <= fx_mul(C2, t) + C1;
        h1_den <= fx_mul(D3, t) + D2;
        h1_t   <= t;
        h2_num <= fx_mul(h1_num, h1_t) + C0;
        h2_den <= fx_mul(h1_den, h1_t) + D1;
        h2_t   <= h1_t;
        h3_num <= h2_num;
        h3_den <= fx_mul(h2_den, h2_t) + ONE;
        h3_t   <= h2_t;
        h_neg  <= {h_neg[1:0], negate};
        if (!rst_n) h_vld <= '0;
        else        h_vld <= {h_vld[1:0], valid_in};
    end

    // Restoring divider, one quotient bit per stage, MSB is the integer bit.
    logic [REM_W-1:0]      d_rem [DIV_STAGES+1];
    logic [FP_WIDTH-1:0]   d_den [DIV_STAGES+1];
    logic [DIV_STAGES-1:0] d_quo [DIV_STAGES+1];
    logic [FP_WIDTH-1:0]   d_t   [DIV_STAGES+1];
    logic                  d_neg [DIV_STAGES+1];
    logic                  d_vld [DIV_STAGES+1];

    assign d_rem[0] = REM_W'(h3_num);
    assign d_den[0] = h3_den;
    assign d_quo[0] = '0;
    assign d_t[0]   = h3_t;
    assign d_neg[0] = h_neg[2];
    assign d_vld[0] = h_vld[2];

    for (genvar s = 0; s < DIV_STAGES; s++) begin : g_div
        logic take;

        assign take = d_rem[s] >= REM_W'(d_den[s]);

        always_ff @(posedge clk) begin
            d_rem[s+1] <= (take ? d_rem[s] - REM_W'(d_den[s]) : d_rem[s]) << 1;
            d_den[s+1] <= d_den[s];
            d_quo[s+1] <= {d_quo[s][DIV_STAGES-2:0], take};
            d_t[s+1]   <= d_t[s];
            d_neg[s+1] <= d_neg[s];
            if (!rst_n) d_vld[s+1] <= 1'b0;
            else        d_vld[s+1] <= d_vld[s];
        end
    end

    logic [FP_WIDTH-1:0] mag;

    assign mag = d_t[DIV_STAGES] - FP_WIDTH'(d_quo[DIV_STAGES]);

    always_ff @(posedge clk) begin
        z <= d_neg[DIV_STAGES] ? -mag : mag;
        if (!rst_n) valid_out <= 1'b0;
        else        valid_out <= d_vld[DIV_STAGES];
    end

endmodule

// ==== rtl/inverse_cdf.sv ====
module inverse_cdf
    import gauss_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  lane_sample_t u_in,
    output lane_sample_t z_out
);

    localparam logic [FP_WIDTH-1:0] ONE  = FP_WIDTH'(1) << FP_QFRAC;
    localparam logic [FP_WIDTH-1:0] HALF = ONE >> 1;
    // Sign travels from the fold register to the rational stage input.
    localparam int NEG_DELAY = ICDF_LATENCY - FOLD_LATENCY - RATIONAL_LATENCY;

    logic [FP_WIDTH-1:0]        x;
    logic                       negate;
    logic                       fold_valid;
    logic signed [FP_WIDTH-1:0] ln_x;
    logic                       ln_valid;
    logic [FP_WIDTH-1:0]        neg2_ln;
    logic                       scale_valid;
    logic [FP_WIDTH-1:0]        t;
    logic                       t_valid;
    logic [NEG_DELAY-1:0]       neg_pipe;
    logic                       z_valid;
    logic signed [FP_WIDTH-1:0] z_val;

    // Fold u into (0, 0.5]; the lower half gives a negative z.
    always_ff @(posedge clk) begin
        x      <= ($unsigned(u_in.value) > HALF) ? ONE - u_in.value : u_in.value;
        negate <= $unsigned(u_in.value) < HALF;
        if (!rst_n) fold_valid <= 1'b0;
        else        fold_valid <= u_in.valid;
    end

    fx_ln_lut u_ln (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (fold_valid),
        .x         (x),
        .valid_out (ln_valid),
        .ln_out    (ln_x)
    );

    // Scale by -2.
    always_ff @(posedge clk) begin
        neg2_ln <= -(ln_x <<< 1);
        if (!rst_n) scale_valid <= 1'b0;
        else        scale_valid <= ln_valid;
    end

    fx_sqrt u_sqrt (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (scale_valid),
        .a         (neg2_ln),
        .valid_out (t_valid),
        .sqrt_out  (t)
    );

    always_ff @(posedge clk) begin
        neg_pipe <= {neg_pipe[NEG_DELAY-2:0], negate};
    end

    zs_rational u_rational (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (t_valid),
        .negate    (neg_pipe[NEG_DELAY-1]),
        .t         (t),
        .valid_out (z_valid),
        .z         (z_val)
    );

    assign z_out.valid = z_valid;
    assign z_out.value = z_val;

endmodule

// ==== rtl/sobol_source.sv ====
module sobol_source
    import gauss_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start,
    input  logic         clear,
    input  logic [31:0]  target,
    output logic         busy,
    output logic         run_done,
    output lane_sample_t u_out [NUM_LANES]
);

    localparam int DRAIN_W = $clog2(ICDF_LATENCY);

    run_state_e         state;
    logic [31:0]        base;
    logic [DRAIN_W-1:0] drain_cnt;

    // First Sobol dimension in base 2 is the bit-reversed index.
    function automatic logic [FP_WIDTH-1:0] radical_inverse(logic [31:0] idx);
        logic [FP_WIDTH-1:0] u;
        u = '0;
        for (int i = 0; i < FP_QFRAC; i++) begin
            u[i] = idx[FP_QFRAC-1-i];
        end
        return u;
    endfunction

    assign busy = (state == RUN_ISSUE) || (state == RUN_DRAIN);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= RUN_IDLE;
            base      <= 32'd1;
            drain_cnt <= '0;
            run_done  <= 1'b0;
        end else begin
            run_done <= 1'b0;
            if (start && !busy) begin
                base <= 32'd1;
                if (target == '0) begin
                    state    <= RUN_DONE;
                    run_done <= 1'b1;
                end else begin
                    state <= RUN_ISSUE;
                end
            end else if (clear) begin
                state <= RUN_IDLE;
            end else begin
                case (state)
                    RUN_ISSUE: begin
                        base <= base + NUM_LANES;
                        if (base + NUM_LANES > target) begin
                            state     <= RUN_DRAIN;
                            drain_cnt <= DRAIN_W'(ICDF_LATENCY - 1);
                        end
                    end
                    RUN_DRAIN: begin
                        // Wait until the last issued point has left the lanes.
                        if (drain_cnt == '0) begin
                            state    <= RUN_DONE;
                            run_done <= 1'b1;
                        end else begin
                            drain_cnt <= drain_cnt - 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Lane k takes index base+k, valid only while it is within the target.
    always_ff @(posedge clk) begin
        for (int k = 0; k < NUM_LANES; k++) begin
            u_out[k].value <= radical_inverse(base + k);
            if (!rst_n) begin
                u_out[k].valid <= 1'b0;
            end else begin
                u_out[k].valid <= (state == RUN_ISSUE) && (base + k <= target);
            end
        end
    end

endmodule

// ==== rtl/moment_accumulator.sv ====
module moment_accumulator
    import gauss_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        clear,
    input  lane_sample_t                z_in [NUM_LANES],
    output logic [31:0]                 count,
    output logic signed [ACC_WIDTH-1:0] sum_z,
    output logic signed [ACC_WIDTH-1:0] sum_sq,
    output logic [FP_WIDTH-1:0]         max_abs
);

    logic [$clog2(NUM_LANES+1)-1:0] add_cnt;
    logic signed [ACC_WIDTH-1:0]    add_z;
    logic signed [ACC_WIDTH-1:0]    add_sq;
    logic [FP_WIDTH-1:0]            cyc_max;

    // Per-cycle totals over the valid lanes.
    always_comb begin
        logic signed [2*FP_WIDTH-1:0] prod;
        logic [FP_WIDTH-1:0]          mag;
        add_cnt = '0;
        add_z   = '0;
        add_sq  = '0;
        cyc_max = max_abs;
        for (int k = 0; k < NUM_LANES; k++) begin
            prod = z_in[k].value * z_in[k].value;
            mag  = z_in[k].value[FP_WIDTH-1] ? -z_in[k].value : z_in[k].value;
            if (z_in[k].valid) begin
                add_cnt = add_cnt + 1'b1;
                add_z   = add_z + ACC_WIDTH'(z_in[k].value);
                add_sq  = add_sq + ACC_WIDTH'(prod >>> FP_QFRAC);
                if (mag > cyc_max) cyc_max = mag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            count   <= '0;
            sum_z   <= '0;
            sum_sq  <= '0;
            max_abs <= '0;
        end else begin
            count   <= count + 32'(add_cnt);
            sum_z   <= sum_z + add_z;
            sum_sq  <= sum_sq + add_sq;
            max_abs <= cyc_max;
        end
    end

endmodule

// ==== rtl/wb_regs.sv ====
module wb_regs
    import gauss_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [3:0]                  wb_adr,
    input  logic [31:0]                 wb_dat_w,
    output logic [31:0]                 wb_dat_r,
    output logic                        wb_ack,
    output logic                        irq,
    output logic                        start,
    output logic                        clear,
    output logic [31:0]                 target,
    input  logic                        busy,
    input  logic                        run_done,
    input  logic [31:0]                 count,
    input  logic signed [ACC_WIDTH-1:0] sum_z,
    input  logic signed [ACC_WIDTH-1:0] sum_sq,
    input  logic [FP_WIDTH-1:0]         max_abs
);

    wb_addr_e addr;
    logic     ctrl_write;
    logic     start_ok;
    logic     run_clear;
    logic     done;

    assign addr       = wb_addr_e'(wb_adr);
    assign ctrl_write = wb_ack && wb_we && (addr == REG_CTRL);
    // A start is taken only between runs, and then also clears the results.
    assign start_ok   = ctrl_write && wb_dat_w[0] && !busy;
    assign run_clear  = (ctrl_write && wb_dat_w[1]) || start_ok;
    assign irq        = done;

    // One ack per access, dropped after a cycle even if stb stays high.
    always_ff @(posedge clk) begin
        if (!rst_n) wb_ack <= 1'b0;
        else        wb_ack <= wb_cyc && wb_stb && !wb_ack;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            target <= '0;
            start  <= 1'b0;
            clear  <= 1'b0;
            done   <= 1'b0;
        end else begin
            start <= start_ok;
            clear <= run_clear;
            if (wb_ack && wb_we && (addr == REG_TARGET)) target <= wb_dat_w;
            if (run_clear)     done <= 1'b0;
            else if (run_done) done <= 1'b1;
        end
    end

    always_comb begin
        case (addr)
            REG_TARGET: wb_dat_r = target;
            REG_STATUS: wb_dat_r = {30'd0, done, busy};
            REG_COUNT:  wb_dat_r = count;
            REG_SUM_LO: wb_dat_r = sum_z[31:0];
            REG_SUM_HI: wb_dat_r = 32'($signed(sum_z[ACC_WIDTH-1:32]));
            REG_SQ_LO:  wb_dat_r = sum_sq[31:0];
            REG_SQ_HI:  wb_dat_r = 32'($signed(sum_sq[ACC_WIDTH-1:32]));
            REG_MAXABS: wb_dat_r = max_abs;
            default:    wb_dat_r = '0;
        endcase
    end

endmodule

// ==== rtl/gauss_rng_top.sv ====
module gauss_rng_top
    import gauss_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [3:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic        irq
);

    logic                        start;
    logic                        clear;
    logic                        busy;
    logic                        run_done;
    logic [31:0]                 target;
    logic [31:0]                 count;
    logic signed [ACC_WIDTH-1:0] sum_z;
    logic signed [ACC_WIDTH-1:0] sum_sq;
    logic [FP_WIDTH-1:0]         max_abs;
    lane_sample_t                u_lane [NUM_LANES];
    lane_sample_t                z_lane [NUM_LANES];

    wb_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .irq      (irq),
        .start    (start),
        .clear    (clear),
        .target   (target),
        .busy     (busy),
        .run_done (run_done),
        .count    (count),
        .sum_z    (sum_z),
        .sum_sq   (sum_sq),
        .max_abs  (max_abs)
    );

    sobol_source u_source (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .clear    (clear),
        .target   (target),
        .busy     (busy),
        .run_done (run_done),
        .u_out    (u_lane)
    );

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        inverse_cdf u_icdf (
            .clk   (clk),
            .rst_n (rst_n),
            .u_in  (u_lane[k]),
            .z_out (z_lane[k])
        );
    end

    moment_accumulator u_acc (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear   (clear),
        .z_in    (z_lane),
        .count   (count),
        .sum_z   (sum_z),
        .sum_sq  (sum_sq),
        .max_abs (max_abs)
    );

endmodule

// ==== sim/tb_gauss_rng.sv ====
module tb_gauss_rng
    import gauss_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int  TIMEOUT_CYCLES = 20_000;
    localparam int  LONG_TARGET    = 1023;
    localparam real SCALE          = 2.0 ** FP_QFRAC;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        irq;

    int          errors;
    int          cycles;
    logic [31:0] rd;
    logic [31:0] wr;
    logic [31:0] tgt;
    longint      sum1;
    longint      sum2;
    longint      sq1;

    gauss_rng_top UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .irq      (irq)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Upper bound on the whole run. It lies well above all scenarios and bus traffic.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic expect_equal(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        assert (actual == expected) else begin
            errors++;
            $display("Error: %0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
        end
    endtask

    task automatic expect_range(input string name, input real value, input real lo,
                                input real hi);
        assert (value >= lo && value <= hi) else begin
            errors++;
            $display("Error: %0t %s expected %f to %f got %f", $time, name, lo, hi, value);
        end
    endtask

    // Ack must drop one cycle after it rose.
    task automatic finish_access();
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);
        assert (!wb_ack) else begin
            errors++;
            $display("Bus ack stayed high for more than one cycle at %0t", $time);
        end
    endtask

    task automatic write_reg(input logic [3:0] adr, input logic [31:0] data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        finish_access();
    endtask

    task automatic read_reg(input logic [3:0] adr, output logic [31:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        data = wb_dat_r;
        finish_access();
    endtask

    // The high word is sign-extended, so both words form a signed 64-bit value.
    task automatic read_wide(input logic [3:0] lo_adr, input logic [3:0] hi_adr,
                             output longint value);
        logic [31:0] lo;
        logic [31:0] hi;
        read_reg(lo_adr, lo);
        read_reg(hi_adr, hi);
        value = $signed({hi, lo});
    endtask

    task automatic start_and_wait(input logic [31:0] target);
        logic [31:0] status;
        write_reg(REG_TARGET, target);
        write_reg(REG_CTRL, 32'd1);
        status = '0;
        while (!status[1]) read_reg(REG_STATUS, status);
        expect_equal("status.busy", 0, status[0]);
        expect_equal("irq", 1, irq);
    endtask

    task automatic run_and_count(input logic [31:0] target);
        logic [31:0] count;
        start_and_wait(target);
        read_reg(REG_COUNT, count);
        expect_equal("count", target, count);
    endtask

    initial begin
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        errors   = 0;
        cycles   = 0;
        void'($urandom(32'h6d08_bef5));
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // Reset values and register map.
        @(negedge clk);
        expect_equal("irq", 0, irq);
        for (int a = REG_STATUS; a <= REG_MAXABS; a++) begin
            read_reg(4'(a), rd);
            expect_equal($sformatf("dat_r[adr %0d]", a), 0, rd);
        end
        repeat (3) begin
            wr = $urandom;
            write_reg(REG_TARGET, wr);
            read_reg(REG_TARGET, rd);
            expect_equal("target", wr, rd);
        end
        for (int a = 9; a < 16; a++) begin
            read_reg(4'(a), rd);
            expect_equal($sformatf("dat_r[adr %0d]", a), 0, rd);
        end
        for (int a = REG_STATUS; a <= REG_MAXABS; a++) begin
            write_reg(4'(a), $urandom);
            read_reg(4'(a), rd);
            expect_equal($sformatf("dat_r[adr %0d]", a), 0, rd);
        end

        // Sample count for random targets. The first is not a lane multiple.
        tgt = 32'($urandom_range(1, 25) * NUM_LANES + $urandom_range(1, NUM_LANES - 1));
        run_and_count(tgt);
        repeat (2) run_and_count(32'($urandom_range(1, 100)));
        run_and_count(32'd0);

        // Symmetry and spread over u = j/1024.
        run_and_count(LONG_TARGET);
        read_wide(REG_SUM_LO, REG_SUM_HI, sum1);
        read_wide(REG_SQ_LO, REG_SQ_HI, sq1);
        expect_range("sum_z", real'(sum1) / SCALE, -0.01, 0.01);
        expect_range("sum_sq/count", real'(sq1) / SCALE / real'(LONG_TARGET), 0.93, 1.03);
        read_reg(REG_MAXABS, rd);
        expect_range("max_abs", real'(rd) / SCALE, 3.05, 3.15);

        // Clear zeroes the results and the done flag.
        write_reg(REG_CTRL, 32'd2);
        for (int a = REG_STATUS; a <= REG_MAXABS; a++) begin
            read_reg(4'(a), rd);
            expect_equal($sformatf("dat_r[adr %0d]", a), 0, rd);
        end
        expect_equal("irq", 0, irq);

        // The sequence is deterministic, so a rerun repeats count and sum.
        start_and_wait(LONG_TARGET);
        read_reg(REG_COUNT, rd);
        expect_equal("count", LONG_TARGET, rd);
        read_wide(REG_SUM_LO, REG_SUM_HI, sum2);
        expect_equal("sum_z", sum1, sum2);

        $display("Checks failed: %0d", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== gauss_rng.f ====
rtl/gauss_pkg.sv
rtl/fx_ln_lut.sv
rtl/fx_sqrt.sv
rtl/zs_rational.sv
rtl/inverse_cdf.sv
rtl/sobol_source.sv
rtl/moment_accumulator.sv
rtl/wb_regs.sv
rtl/gauss_rng_top.sv
sim/tb_gauss_rng.sv

// ==== build.sh ====
#!/bin/sh
# Compile the testbench and the design with Verilator, run it, and check the log.
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f gauss_rng.f --top-module tb_gauss_rng \
    -Mdir "$BUILD_DIR" -o tb_gauss_rng
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/tb_gauss_rng" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
fi
exit 1
